// ==== files.f ====
+incdir+include
hw/align_pkg.sv
hw/mem_wr_if.sv
hw/wr_lane_encode.sv
hw/wr_row_merge.sv
hw/rd_port_pipe.sv
hw/align_parity_mrnw.sv
tb/sram_model.sv
tb/tb_align_parity_mrnw.sv

// ==== hw/align_parity_mrnw.sv ====
module align_parity_mrnw #(
  parameter int WIDTH = align_pkg::DEF_WIDTH,
  parameter int NUMWRPT = align_pkg::DEF_NUMWRPT,
  parameter int NUMRDPT = align_pkg::DEF_NUMRDPT,
  parameter int BITADDR = align_pkg::DEF_BITADDR,
  parameter int NUMWRDS = align_pkg::DEF_NUMWRDS,
  parameter int BITWRDS = align_pkg::DEF_BITWRDS,
  parameter int SRAM_DELAY = align_pkg::DEF_SRAM_DELAY
) (
  input  logic                                      clk,
  input  logic                                      reset,

  // Write ports
  input  logic [NUMWRPT-1:0]                        write,
  input  logic [NUMWRPT*BITADDR-1:0]                wr_adr,
  input  logic [NUMWRPT*WIDTH-1:0]                  din,

  // Read ports
  input  logic [NUMRDPT-1:0]                        read,
  input  logic [NUMRDPT*BITADDR-1:0]                rd_adr,
  output logic [NUMRDPT-1:0]                        rd_vld,
  output logic [NUMRDPT*WIDTH-1:0]                  rd_dout,
  output logic [NUMRDPT-1:0]                        rd_serr,
  output logic [NUMRDPT*BITADDR-1:0]                rd_padr,

  // SRAM side
  output logic [NUMWRPT-1:0]                        mem_write,
  output logic [NUMWRPT*(BITADDR-BITWRDS)-1:0]      mem_wr_adr,
  output logic [NUMWRPT*NUMWRDS*(WIDTH+1)-1:0]      mem_bw,
  output logic [NUMWRPT*NUMWRDS*(WIDTH+1)-1:0]      mem_din,
  output logic [NUMRDPT-1:0]                        mem_read,
  output logic [NUMRDPT*(BITADDR-BITWRDS)-1:0]      mem_rd_adr,
  input  logic [NUMRDPT*NUMWRDS*(WIDTH+1)-1:0]      mem_rd_dout
);

  `include "align_geom.svh"

  // ****************************************
  // Write path
  // ****************************************

  mem_wr_if #(
    .BITSROW(BITSROW),
    .ROWWDTH(ROWWDTH)
  ) wr_req [NUMWRPT] ();

  for (genvar p = 0; p < NUMWRPT; p++) begin : g_wr
    wr_lane_encode #(
      .WIDTH(WIDTH),
      .BITADDR(BITADDR),
      .NUMWRDS(NUMWRDS),
      .BITWRDS(BITWRDS)
    ) u_wr_lane_encode (
      .write(write[p]),
      .adr(wr_adr[p*BITADDR +: BITADDR]),
      .din(din[p*WIDTH +: WIDTH]),
      .req(wr_req[p])
    );
  end

  // All cross-port interaction happens in here
  wr_row_merge #(
    .NUMWRPT(NUMWRPT),
    .BITSROW(BITSROW),
    .ROWWDTH(ROWWDTH)
  ) u_wr_row_merge (
    .req(wr_req),
    .mem_write(mem_write),
    .mem_wr_adr(mem_wr_adr),
    .mem_bw(mem_bw),
    .mem_din(mem_din)
  );

  // ****************************************
  // Read path
  // ****************************************

  // Read ports are independent of each other
  for (genvar p = 0; p < NUMRDPT; p++) begin : g_rd
    rd_port_pipe #(
      .WIDTH(WIDTH),
      .BITADDR(BITADDR),
      .NUMWRDS(NUMWRDS),
      .BITWRDS(BITWRDS),
      .SRAM_DELAY(SRAM_DELAY)
    ) u_rd_port_pipe (
      .clk(clk),
      .reset(reset),
      .read(read[p]),
      .adr(rd_adr[p*BITADDR +: BITADDR]),
      .mem_read(mem_read[p]),
      .mem_rd_adr(mem_rd_adr[p*BITSROW +: BITSROW]),
      .mem_rd_dout(mem_rd_dout[p*ROWWDTH +: ROWWDTH]),
      .rd_vld(rd_vld[p]),
      .rd_dout(rd_dout[p*WIDTH +: WIDTH]),
      .rd_serr(rd_serr[p]),
      .rd_padr(rd_padr[p*BITADDR +: BITADDR])
    );
  end

endmodule

// ==== hw/align_pkg.sv ====
package align_pkg;

  // ****************************************
  // Default geometry
  // ****************************************

  localparam int DEF_WIDTH = 32;
  localparam int DEF_NUMWRPT = 2;
  localparam int DEF_NUMRDPT = 2;
  localparam int DEF_BITADDR = 10;
  localparam int DEF_NUMWRDS = 4;       // Words packed in one SRAM row
  localparam int DEF_BITWRDS = 2;
  localparam int DEF_SRAM_DELAY = 2;    // Cycles from mem_read to mem_rd_dout

  // ****************************************
  // Parity
  // ****************************************

  // Widest word the parity helper accepts
  // Narrower words are zero extended by the caller, which leaves the XOR unchanged
  localparam int PAR_MAXW = 128;

  function automatic logic parity_of(input logic [PAR_MAXW-1:0] data);
    return ^data;
  endfunction

endpackage

// ==== hw/mem_wr_if.sv ====
// One port's write request toward the SRAM, already aligned to a full row
interface mem_wr_if #(
  parameter int BITSROW = align_pkg::DEF_BITADDR - align_pkg::DEF_BITWRDS,
  parameter int ROWWDTH = align_pkg::DEF_NUMWRDS * (align_pkg::DEF_WIDTH + 1)
);

  logic               write;  // Single-cycle strobe
  logic [BITSROW-1:0] row;
  logic [ROWWDTH-1:0] bw;     // Bit-write mask across the row
  logic [ROWWDTH-1:0] din;

  modport src (
    output write,
    output row,
    output bw,
    output din
  );

  modport sink (
    input write,
    input row,
    input bw,
    input din
  );

endinterface

// ==== hw/rd_port_pipe.sv ====
module rd_port_pipe #(
  parameter int WIDTH = align_pkg::DEF_WIDTH,
  parameter int BITADDR = align_pkg::DEF_BITADDR,
  parameter int NUMWRDS = align_pkg::DEF_NUMWRDS,
  parameter int BITWRDS = align_pkg::DEF_BITWRDS,
  parameter int SRAM_DELAY = align_pkg::DEF_SRAM_DELAY
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             read,
  input  logic [BITADDR-1:0]               adr,
  output logic                             mem_read,
  output logic [BITADDR-BITWRDS-1:0]       mem_rd_adr,
  input  logic [NUMWRDS*(WIDTH+1)-1:0]     mem_rd_dout,
  output logic                             rd_vld,
  output logic [WIDTH-1:0]                 rd_dout,
  output logic                             rd_serr,
  output logic [BITADDR-1:0]               rd_padr
);

  `include "align_geom.svh"

  localparam int LAST = SRAM_DELAY - 1;   // Stage lined up with mem_rd_dout

  logic [SRAM_DELAY-1:0] vld_q;
  logic [BITWRDS-1:0]    wadr_q [SRAM_DELAY];
  logic [BITSROW-1:0]    row_q  [SRAM_DELAY];

  logic [ROWWDTH-1:0]              row_data;
  logic [MEMWDTH-1:0]              word;
  logic [align_pkg::PAR_MAXW-1:0]  par_in;

  // ****************************************
  // SRAM request
  // ****************************************

  assign mem_read = read;
  assign mem_rd_adr = adr[BITADDR-1:BITWRDS];

  // ****************************************
  // Tag pipeline
  // ****************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= read;
      for (int s = 1; s < SRAM_DELAY; s++) begin
        vld_q[s] <= vld_q[s-1];
      end
    end
  end

  // Address tags ride along with the valid bits
  always_ff @(posedge clk) begin
    wadr_q[0] <= adr[BITWRDS-1:0];
    row_q[0] <= mem_rd_adr;
    for (int s = 1; s < SRAM_DELAY; s++) begin
      wadr_q[s] <= wadr_q[s-1];
      row_q[s] <= row_q[s-1];
    end
  end

  // ****************************************
  // Word select and parity check
  // ****************************************

  assign row_data = mem_rd_dout;
  assign word = MEMWDTH'(row_data >> (wadr_q[LAST] * MEMWDTH));
  assign par_in = {{(align_pkg::PAR_MAXW - MEMWDTH){1'b0}}, word};

  assign rd_vld = vld_q[LAST];
  assign rd_dout = word[WIDTH-1:0];  // Parity bit is dropped here

  // Any odd number of flipped bits in the stored word shows up here
  assign rd_serr = vld_q[LAST] && align_pkg::parity_of(par_in);

  // Row and word position put back together give the read address
  assign rd_padr = {row_q[LAST], wadr_q[LAST]};

endmodule

// ==== hw/wr_lane_encode.sv ====
module wr_lane_encode #(
  parameter int WIDTH = align_pkg::DEF_WIDTH,
  parameter int BITADDR = align_pkg::DEF_BITADDR,
  parameter int NUMWRDS = align_pkg::DEF_NUMWRDS,
  parameter int BITWRDS = align_pkg::DEF_BITWRDS
) (
  input  logic               write,
  input  logic [BITADDR-1:0] adr,
  input  logic [WIDTH-1:0]   din,
  mem_wr_if.src              req
);

  `include "align_geom.svh"

  logic [BITWRDS-1:0]              wadr;    // Word position inside the row
  logic [align_pkg::PAR_MAXW-1:0]  par_in;
  logic [MEMWDTH-1:0]              word;

  assign wadr = adr[BITWRDS-1:0];

  // Row index goes out even without a write
  assign req.row = adr[BITADDR-1:BITWRDS];

  assign par_in = {{(align_pkg::PAR_MAXW - WIDTH){1'b0}}, din};

  // Parity sits above the data bits
  assign word = {align_pkg::parity_of(par_in), din};

  // ****************************************
  // Lane placement
  // ****************************************

  always_comb begin
    req.write = write;
    req.bw = '0;
    req.din = '0;
    if (write) begin
      // Lane 0 occupies the low MEMWDTH bits of the row
      req.bw = ROWWDTH'({MEMWDTH{1'b1}}) << (wadr * MEMWDTH);
      req.din = ROWWDTH'(word) << (wadr * MEMWDTH);
    end
  end

endmodule

// ==== hw/wr_row_merge.sv ====
module wr_row_merge #(
  parameter int NUMWRPT = align_pkg::DEF_NUMWRPT,
  parameter int BITSROW = align_pkg::DEF_BITADDR - align_pkg::DEF_BITWRDS,
  parameter int ROWWDTH = align_pkg::DEF_NUMWRDS * (align_pkg::DEF_WIDTH + 1)
) (
  mem_wr_if.sink                       req [NUMWRPT],
  output logic [NUMWRPT-1:0]           mem_write,
  output logic [NUMWRPT*BITSROW-1:0]   mem_wr_adr,
  output logic [NUMWRPT*ROWWDTH-1:0]   mem_bw,
  output logic [NUMWRPT*ROWWDTH-1:0]   mem_din
);

  logic [NUMWRPT-1:0] wr_in;
  logic [BITSROW-1:0] row_in [NUMWRPT];
  logic [ROWWDTH-1:0] bw_in  [NUMWRPT];
  logic [ROWWDTH-1:0] din_in [NUMWRPT];

  logic [NUMWRPT-1:0] wr_m;
  logic [ROWWDTH-1:0] bw_m   [NUMWRPT];
  logic [ROWWDTH-1:0] din_m  [NUMWRPT];

  // Interface arrays need constant indices, so unpack them here
  for (genvar g = 0; g < NUMWRPT; g++) begin : g_unpack
    assign wr_in[g]  = req[g].write;
    assign row_in[g] = req[g].row;
    assign bw_in[g]  = req[g].bw;
    assign din_in[g] = req[g].din;
  end

  // ****************************************
  // Same-row merge
  // ****************************************

  // A lower port hitting the same row folds into the higher one and is dropped.
  // Ports are visited in ascending order, so the highest writer of a row ends up
  // carrying all of them
  always_comb begin
    wr_m = wr_in;
    for (int i = 0; i < NUMWRPT; i++) begin
      bw_m[i] = bw_in[i];
      din_m[i] = din_in[i];
    end
    for (int i = 1; i < NUMWRPT; i++) begin
      for (int j = 0; j < i; j++) begin
        if (wr_m[j] && wr_m[i] && (row_in[j] == row_in[i])) begin
          wr_m[j] = 1'b0;
          din_m[i] = (din_m[j] & ~bw_m[i]) | din_m[i];  // Higher port keeps its own word
          bw_m[i] = bw_m[j] | bw_m[i];
        end
      end
    end
  end

  always_comb begin
    mem_write = wr_m;
    mem_wr_adr = '0;
    mem_bw = '0;
    mem_din = '0;
    for (int i = 0; i < NUMWRPT; i++) begin
      mem_wr_adr[i*BITSROW +: BITSROW] = row_in[i];
      mem_bw[i*ROWWDTH +: ROWWDTH] = bw_m[i];
      mem_din[i*ROWWDTH +: ROWWDTH] = din_m[i];
    end
  end

endmodule

// ==== include/align_geom.svh ====
// Geometry derived from the enclosing module's parameters
// Expects WIDTH, BITADDR, BITWRDS and NUMWRDS to be in scope where this is included

// ****************************************
// Stored word and row geometry
// ****************************************

localparam int MEMWDTH = WIDTH + 1;            // Data with parity bit on top

localparam int BITSROW = BITADDR - BITWRDS;    // Upper address bits select the row

localparam int ROWWDTH = NUMWRDS * MEMWDTH;    // One full SRAM row

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compiles and runs the align_parity_mrnw testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_align_parity_mrnw
OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f files.f --top-module "$TOP" -Mdir "$OBJ_DIR" -o "$TOP"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator compile failed with status $status"
  exit 1
fi

"./$OBJ_DIR/$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

echo "Simulation finished cleanly"
exit 0

// ==== tb/align_trace.txt ====
// One line per cycle, all values hex. Columns
// w0 wa0 wd0 w1 wa1 wd1 r0 ra0 exp_dout0 exp_serr0 r1 ra1 exp_dout1 exp_serr1 inj_row inj_bit inj_cnt
// Read expectations apply SRAM_DELAY cycles after the line. First value is the line count
12
0 000 0 0 000 0 0 000 0 0 0 000 0 0 0 0 0
0 000 0 0 000 0 0 000 0 0 0 000 0 0 0 0 0
// Two rows written at once
1 010 11111111 1 021 22222222 0 000 0 0 0 000 0 0 0 0 0
// Same row, different words
1 00c aaaa0001 1 00d bbbb0002 0 000 0 0 0 000 0 0 0 0 0
// Same address, port 1 wins
1 030 12345678 1 030 87654321 1 010 11111111 0 1 021 22222222 0 0 0 0
0 000 0 0 000 0 1 00c aaaa0001 0 1 00d bbbb0002 0 0 0 0
// Read of 031 while it is written returns the old value
1 031 5a5a5a5a 0 000 0 1 030 87654321 0 1 031 00000000 0 0 0 0
// Back-to-back reads on both ports
0 000 0 0 000 0 1 031 5a5a5a5a 0 1 010 11111111 0 0 0 0
0 000 0 0 000 0 1 021 22222222 0 1 00c aaaa0001 0 0 0 0
0 000 0 0 000 0 1 00d bbbb0002 0 1 030 87654321 0 0 0 0
0 000 0 1 00c c0ffee00 1 00c aaaa0001 0 1 031 5a5a5a5a 0 0 0 0
0 000 0 0 000 0 1 00c c0ffee00 0 1 00d bbbb0002 0 0 0 0
// Flip data bit 5 of word 1 in row 3
0 000 0 0 000 0 0 000 0 0 0 000 0 0 03 26 1
0 000 0 0 000 0 1 00d bbbb0022 1 1 00c c0ffee00 0 0 0 0
0 000 0 0 000 0 1 00d bbbb0022 1 0 000 0 0 0 0 0
0 000 0 0 000 0 0 000 0 0 0 000 0 0 0 0 0
// Top and bottom of the address range
1 3ff deadbeef 1 000 0badf00d 0 000 0 0 0 000 0 0 0 0 0
0 000 0 0 000 0 1 3ff deadbeef 0 1 000 0badf00d 0 0 0 0

// ==== tb/sram_model.sv ====
// Wide SRAM with per-bit write enables and a fixed read latency
module sram_model #(
  parameter int NUMWRPT = 2,
  parameter int NUMRDPT = 2,
  parameter int BITSROW = 8,
  parameter int ROWWDTH = 132,
  parameter int SRAM_DELAY = 2
) (
  input  logic                         clk,
  input  logic [NUMWRPT-1:0]           mem_write,
  input  logic [NUMWRPT*BITSROW-1:0]   mem_wr_adr,
  input  logic [NUMWRPT*ROWWDTH-1:0]   mem_bw,
  input  logic [NUMWRPT*ROWWDTH-1:0]   mem_din,
  input  logic [NUMRDPT-1:0]           mem_read,
  input  logic [NUMRDPT*BITSROW-1:0]   mem_rd_adr,
  output logic [NUMRDPT*ROWWDTH-1:0]   mem_rd_dout,
  input  logic [BITSROW-1:0]           inj_row,   // Row that gets corrupted
  input  logic [15:0]                  inj_bit,   // First flipped bit within the row
  input  logic [7:0]                   inj_cnt    // Number of adjacent bits to flip
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUMROWS = 1 << BITSROW;

  logic [ROWWDTH-1:0] mem [NUMROWS];
  logic [ROWWDTH-1:0] rd_pipe [NUMRDPT][SRAM_DELAY];

  initial begin
    for (int r = 0; r < NUMROWS; r++) begin
      mem[r] = '0;
    end
  end

  always @(posedge clk) begin
    logic [BITSROW-1:0] row;
    logic [ROWWDTH-1:0] bw;
    logic [ROWWDTH-1:0] flip;
    // Read capture comes first, so a write in the same cycle is not seen
    for (int p = 0; p < NUMRDPT; p++) begin
      if (mem_read[p]) begin
        rd_pipe[p][0] <= mem[mem_rd_adr[p*BITSROW +: BITSROW]];
      end
      for (int s = 1; s < SRAM_DELAY; s++) begin
        rd_pipe[p][s] <= rd_pipe[p][s-1];
      end
    end
    for (int p = 0; p < NUMWRPT; p++) begin
      if (mem_write[p]) begin
        row = mem_wr_adr[p*BITSROW +: BITSROW];
        bw = mem_bw[p*ROWWDTH +: ROWWDTH];
        mem[row] = (mem[row] & ~bw) | (mem_din[p*ROWWDTH +: ROWWDTH] & bw);
      end
    end
    // ****************************************
    // Error injection
    // ****************************************
    flip = ((ROWWDTH'(1) << inj_cnt) - ROWWDTH'(1)) << inj_bit;
    mem[inj_row] = mem[inj_row] ^ flip;   // Zero count leaves the row alone
  end

  always_comb begin
    for (int p = 0; p < NUMRDPT; p++) begin
      mem_rd_dout[p*ROWWDTH +: ROWWDTH] = rd_pipe[p][SRAM_DELAY-1];
    end
  end

endmodule

// ==== tb/tb_align_parity_mrnw.sv ====
module tb_align_parity_mrnw;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int WIDTH = align_pkg::DEF_WIDTH;
  localparam int NUMWRPT = align_pkg::DEF_NUMWRPT;
  localparam int NUMRDPT = align_pkg::DEF_NUMRDPT;
  localparam int BITADDR = align_pkg::DEF_BITADDR;
  localparam int NUMWRDS = align_pkg::DEF_NUMWRDS;
  localparam int BITWRDS = align_pkg::DEF_BITWRDS;
  localparam int SRAM_DELAY = align_pkg::DEF_SRAM_DELAY;
  localparam int BITSROW = BITADDR - BITWRDS;
  localparam int ROWWDTH = NUMWRDS * (WIDTH + 1);
  localparam int NCOL = 3 * NUMWRPT + 4 * NUMRDPT + 3;   // Columns per trace line
  localparam int MAXLINES = 256;
  localparam int CLK_PERIOD = 20;
  localparam int RESET_CYCLES = 5;

  logic clk;
  logic reset;
  logic [NUMWRPT-1:0] write;
  logic [NUMWRPT*BITADDR-1:0] wr_adr;
  logic [NUMWRPT*WIDTH-1:0] din;
  logic [NUMRDPT-1:0] read;
  logic [NUMRDPT*BITADDR-1:0] rd_adr;
  logic [NUMRDPT-1:0] rd_vld;
  logic [NUMRDPT*WIDTH-1:0] rd_dout;
  logic [NUMRDPT-1:0] rd_serr;
  logic [NUMRDPT*BITADDR-1:0] rd_padr;
  logic [NUMWRPT-1:0] mem_write;
  logic [NUMWRPT*BITSROW-1:0] mem_wr_adr;
  logic [NUMWRPT*ROWWDTH-1:0] mem_bw;
  logic [NUMWRPT*ROWWDTH-1:0] mem_din;
  logic [NUMRDPT-1:0] mem_read;
  logic [NUMRDPT*BITSROW-1:0] mem_rd_adr;
  logic [NUMRDPT*ROWWDTH-1:0] mem_rd_dout;
  logic [BITSROW-1:0] inj_row;
  logic [15:0] inj_bit;
  logic [7:0] inj_cnt;

  logic [31:0] trace_mem [1 + MAXLINES * NCOL];   // Word 0 holds the line count
  int n_lines = 0;
  int cur_cyc;
  logic checking;
  integer seed;

  align_parity_mrnw #(
    .WIDTH(WIDTH), .NUMWRPT(NUMWRPT), .NUMRDPT(NUMRDPT), .BITADDR(BITADDR),
    .NUMWRDS(NUMWRDS), .BITWRDS(BITWRDS), .SRAM_DELAY(SRAM_DELAY)
  ) u_align_parity_mrnw (
    .clk(clk), .reset(reset), .write(write), .wr_adr(wr_adr), .din(din),
    .read(read), .rd_adr(rd_adr), .rd_vld(rd_vld), .rd_dout(rd_dout),
    .rd_serr(rd_serr), .rd_padr(rd_padr), .mem_write(mem_write),
    .mem_wr_adr(mem_wr_adr), .mem_bw(mem_bw), .mem_din(mem_din),
    .mem_read(mem_read), .mem_rd_adr(mem_rd_adr), .mem_rd_dout(mem_rd_dout)
  );

  sram_model #(
    .NUMWRPT(NUMWRPT), .NUMRDPT(NUMRDPT), .BITSROW(BITSROW),
    .ROWWDTH(ROWWDTH), .SRAM_DELAY(SRAM_DELAY)
  ) u_sram_model (
    .clk(clk), .mem_write(mem_write), .mem_wr_adr(mem_wr_adr), .mem_bw(mem_bw),
    .mem_din(mem_din), .mem_read(mem_read), .mem_rd_adr(mem_rd_adr),
    .mem_rd_dout(mem_rd_dout), .inj_row(inj_row), .inj_bit(inj_bit), .inj_cnt(inj_cnt)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Lines outside the trace read as idle
  function automatic logic [31:0] trace_field(input int line, input int col);
    if (line < 0 || line >= n_lines) return 32'h0;
    return trace_mem[1 + line * NCOL + col];
  endfunction

  function automatic logic [31:0] row_of(input logic [31:0] adr);
    logic [31:0] mask;
    mask = (32'h1 << BITADDR) - 32'h1;
    return (adr & mask) >> BITWRDS;
  endfunction

  task automatic check_value(input string name, input int port,
                             input logic [63:0] expected, input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("mismatch at %0d ns: %s[%0d] expected %h, got %h",
               $time, name, port, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopping on the first error");
    end
  endtask

  // ****************************************
  // Stimulus
  // ****************************************

  task automatic drive_line(input int line);
    logic [31:0] v;
    int rc;
    for (int p = 0; p < NUMWRPT; p++) begin
      write[p] <= (trace_field(line, 3 * p) != 32'h0);
      v = trace_field(line, 3 * p + 1);
      wr_adr[p*BITADDR +: BITADDR] <= v[BITADDR-1:0];
      v = trace_field(line, 3 * p + 2);
      if (trace_field(line, 3 * p) == 32'h0) v = $random(seed);  // Noise on idle data
      din[p*WIDTH +: WIDTH] <= v[WIDTH-1:0];
    end
    for (int p = 0; p < NUMRDPT; p++) begin
      rc = 3 * NUMWRPT + 4 * p;
      read[p] <= (trace_field(line, rc) != 32'h0);
      v = trace_field(line, rc + 1);
      rd_adr[p*BITADDR +: BITADDR] <= v[BITADDR-1:0];
    end
    v = trace_field(line, NCOL - 3);
    inj_row <= v[BITSROW-1:0];
    v = trace_field(line, NCOL - 2);
    inj_bit <= v[15:0];
    v = trace_field(line, NCOL - 1);
    inj_cnt <= v[7:0];
  endtask

  // ****************************************
  // Checks
  // ****************************************

  task automatic check_cycle(input int cyc);
    int rl;
    int rc;
    logic exp_wr;
    logic exp_rd;
    logic exp_vld;
    logic [31:0] v;
    rl = cyc - SRAM_DELAY;   // Trace line whose reads complete now
    for (int j = 0; j < NUMWRPT; j++) begin
      exp_wr = (trace_field(cyc, 3 * j) != 32'h0);
      for (int i = j + 1; i < NUMWRPT; i++) begin
        // A higher port on the same row absorbs this write
        if (trace_field(cyc, 3 * i) != 32'h0) begin
          if (row_of(trace_field(cyc, 3 * i + 1)) == row_of(trace_field(cyc, 3 * j + 1))) begin
            exp_wr = 1'b0;
          end
        end
      end
      check_value("mem_write", j, 64'(exp_wr), 64'(mem_write[j]));
    end
    for (int p = 0; p < NUMRDPT; p++) begin
      rc = 3 * NUMWRPT + 4 * p;
      exp_rd = (trace_field(cyc, rc) != 32'h0);
      check_value("mem_read", p, 64'(exp_rd), 64'(mem_read[p]));
      exp_vld = (trace_field(rl, rc) != 32'h0);
      check_value("rd_vld", p, 64'(exp_vld), 64'(rd_vld[p]));
      if (exp_vld) begin
        v = trace_field(rl, rc + 2);
        check_value("rd_dout", p, 64'(v[WIDTH-1:0]), 64'(rd_dout[p*WIDTH +: WIDTH]));
        exp_wr = (trace_field(rl, rc + 3) != 32'h0);
        check_value("rd_serr", p, 64'(exp_wr), 64'(rd_serr[p]));
        v = trace_field(rl, rc + 1);
        check_value("rd_padr", p, 64'(v[BITADDR-1:0]), 64'(rd_padr[p*BITADDR +: BITADDR]));
      end
    end
  endtask

  always @(negedge clk) begin
    if (checking) check_cycle(cur_cyc);
  end

  initial begin
    seed = 32'he547d7a0;
    clk = 1'b0;
    reset = 1'b1;
    write = '0;
    wr_adr = '0;
    din = '0;
    read = '1;   // Reads stay high through reset and must not reach rd_vld
    rd_adr = '0;
    inj_row = '0;
    inj_bit = '0;
    inj_cnt = '0;
    checking = 1'b0;
    cur_cyc = 0;
    $readmemh("tb/align_trace.txt", trace_mem);
    if (int'(trace_mem[0]) < 1 || int'(trace_mem[0]) > MAXLINES) begin
      $display("The trace file holds no cycle lines or more than %0d", MAXLINES);
      $display("TEST RESULT: FAIL");
      $fatal(1, "unusable trace file");
    end
    n_lines = int'(trace_mem[0]);
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    read <= '0;
    for (int c = 0; c < n_lines + SRAM_DELAY + 2; c++) begin
      @(posedge clk);
      drive_line(c);
      cur_cyc = c;
      checking = 1'b1;
    end
    @(posedge clk);
    $display("TEST RESULT: PASS");
    $finish;
  end

  // Watchdog sized from the trace length
  initial begin
    longint limit;
    wait (n_lines > 0);
    limit = longint'(n_lines + SRAM_DELAY + 20) * CLK_PERIOD;
    #(limit);
    $display("The run did not finish within %0d ns", limit);
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule
